//--- filelist.f
hw/fetch_pkg.sv
hw/isa_pkg.sv
hw/fetch_pc_gen.sv
hw/icache.sv
hw/fetch_queue.sv
hw/instr_predecode.sv
hw/fetch_top.sv
testbench/tb_mem_model.sv
testbench/tb_fetch_top.sv

//--- testbench/tb_fetch_top.sv
module tb_fetch_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LINES           = 16;
    localparam int QUEUE_DEPTH     = 4;
    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int TOTAL_WORDS     = 16 + 16 + 4 + 4 + 40;
    localparam int CYCLES_PER_WORD = 40;
    localparam int WATCHDOG_NS     =
        (TOTAL_WORDS * CYCLES_PER_WORD + RESET_CYCLES + 100) * CLK_PERIOD;
    localparam logic [31:0] SEED   = 32'h7226_afea;

    typedef struct packed {
        isa_pkg::instr_class_t cls;
        logic [4:0]            rd;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        fetch_pkg::word_t      imm;
    } dec_exp_t;

    logic                  clk;
    logic                  rst;
    logic                  start;
    fetch_pkg::addr_t      start_addr;
    fetch_pkg::len_t       fetch_len;
    logic                  mem_req_valid;
    fetch_pkg::addr_t      mem_req_addr;
    logic                  mem_req_ready;
    fetch_pkg::word_t      mem_req_data;
    logic                  dec_valid;
    logic                  dec_ready;
    fetch_pkg::addr_t      dec_pc;
    isa_pkg::instr_class_t dec_class;
    logic [4:0]            dec_rd;
    logic [4:0]            dec_rs1;
    logic [4:0]            dec_rs2;
    fetch_pkg::word_t      dec_imm;

    logic                  random_ready;
    fetch_pkg::addr_t      exp_q [$];
    int unsigned           errors;
    int unsigned           tests_passed;
    int unsigned           tests_failed;
    logic [3:0]            class_seen;
    logic                  neg_imm_seen;
    logic                  pos_imm_seen;
    int unsigned           seed_value;

    fetch_top #(
        .LINES      (LINES),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .start_addr   (start_addr),
        .fetch_len    (fetch_len),
        .mem_req_valid(mem_req_valid),
        .mem_req_addr (mem_req_addr),
        .mem_req_ready(mem_req_ready),
        .mem_req_data (mem_req_data),
        .dec_valid    (dec_valid),
        .dec_ready    (dec_ready),
        .dec_pc       (dec_pc),
        .dec_class    (dec_class),
        .dec_rd       (dec_rd),
        .dec_rs1      (dec_rs1),
        .dec_rs2      (dec_rs2),
        .dec_imm      (dec_imm)
    );

    tb_mem_model u_mem (
        .clk          (clk),
        .rst          (rst),
        .mem_req_valid(mem_req_valid),
        .mem_req_addr (mem_req_addr),
        .mem_req_ready(mem_req_ready),
        .mem_req_data (mem_req_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Predecode rules applied to the memory contents at addr.
    function automatic dec_exp_t expect_decode(input fetch_pkg::addr_t addr);
        fetch_pkg::word_t w;
        dec_exp_t         e;
        w     = u_mem.mem_word(addr);
        e.cls = isa_pkg::CLASS_OTHER;
        e.rd  = '0;
        e.rs1 = '0;
        e.rs2 = '0;
        e.imm = '0;
        if (w[6:0] == isa_pkg::OP_REG)
        begin
            e.cls = isa_pkg::CLASS_REG;
            e.rd  = w[11:7];
            e.rs1 = w[19:15];
            e.rs2 = w[24:20];
        end
        else if (w[6:0] == isa_pkg::OP_IMM || w[6:0] == isa_pkg::OP_LOAD)
        begin
            e.cls = (w[6:0] == isa_pkg::OP_IMM) ? isa_pkg::CLASS_IMM : isa_pkg::CLASS_LOAD;
            e.rd  = w[11:7];
            e.rs1 = w[19:15];
            e.imm = {{20{w[31]}}, w[31:20]};
        end
        return e;
    endfunction

    always @(posedge clk)
    begin : check_transfer
        fetch_pkg::addr_t exp_pc;
        dec_exp_t         want;
        if (!rst && dec_valid && dec_ready)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                $display("ERROR: decoded output at pc %h with no fetch outstanding", dec_pc);
                errors++;
            end
            if (exp_q.size() != 0)
            begin
                exp_pc = exp_q.pop_front();
                want   = expect_decode(exp_pc);
                assert (dec_pc == exp_pc)
                else
                begin
                    $display("MISMATCH dec_pc expected %h actual %h", exp_pc, dec_pc);
                    errors++;
                end
                assert (dec_class == want.cls)
                else
                begin
                    $display("MISMATCH dec_class expected %h actual %h", want.cls, dec_class);
                    errors++;
                end
                assert (dec_rd == want.rd && dec_rs1 == want.rs1)
                else
                begin
                    $display("MISMATCH dec_rd/dec_rs1 expected %h/%h actual %h/%h",
                             want.rd, want.rs1, dec_rd, dec_rs1);
                    errors++;
                end
                assert (dec_rs2 == want.rs2)
                else
                begin
                    $display("MISMATCH dec_rs2 expected %h actual %h", want.rs2, dec_rs2);
                    errors++;
                end
                assert (dec_imm == want.imm)
                else
                begin
                    $display("MISMATCH dec_imm expected %h actual %h", want.imm, dec_imm);
                    errors++;
                end
                // Format rules checked on the decoded fields alone.
                if (dec_class == isa_pkg::CLASS_IMM || dec_class == isa_pkg::CLASS_LOAD)
                begin
                    assert (dec_rs2 == 5'd0 && dec_imm[31:12] == {20{dec_imm[11]}})
                    else
                    begin
                        $display("MISMATCH dec_rs2/dec_imm expected 00/sign-extended actual %h/%h",
                                 dec_rs2, dec_imm);
                        errors++;
                    end
                    if (dec_imm[11])
                    begin
                        neg_imm_seen = 1'b1;
                    end
                    else
                    begin
                        pos_imm_seen = 1'b1;
                    end
                end
                if (dec_class == isa_pkg::CLASS_REG)
                begin
                    assert (dec_imm == '0)
                    else
                    begin
                        $display("MISMATCH dec_imm expected 00000000 actual %h", dec_imm);
                        errors++;
                    end
                end
                class_seen[dec_class] = 1'b1;
            end
        end
    end

    // Random stall on the output side when enabled.
    always @(posedge clk)
    begin
        if (random_ready)
        begin
            dec_ready <= (($urandom % 2) == 0);
        end
        else
        begin
            dec_ready <= 1'b1;
        end
    end

    task automatic report_test(input string name, input int unsigned err_before);
        if (errors == err_before)
        begin
            tests_passed++;
            $display("test %s: passed", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic run_fetch(input string name, input fetch_pkg::addr_t addr,
                             input int len, input int exp_reqs);
        fetch_pkg::addr_t base;
        int unsigned      err_before;
        int unsigned      req_before;
        int unsigned      new_reqs;
        base       = addr & ~32'h3;
        err_before = errors;
        req_before = u_mem.req_count;
        for (int i = 0; i < len; i++)
        begin
            exp_q.push_back(base + fetch_pkg::addr_t'(4 * i));
        end
        @(posedge clk);
        start      <= 1'b1;
        start_addr <= addr;
        fetch_len  <= fetch_pkg::len_t'(len);
        @(posedge clk);
        start <= 1'b0;
        while (exp_q.size() != 0)
        begin
            @(posedge clk);
        end
        @(posedge clk);
        new_reqs = u_mem.req_count - req_before;
        assert (new_reqs == exp_reqs)
        else
        begin
            $display("MISMATCH mem_requests expected %h actual %h", exp_reqs, new_reqs);
            errors++;
        end
        report_test(name, err_before);
    endtask

    task automatic check_format_coverage();
        int unsigned err_before;
        err_before = errors;
        assert (class_seen == 4'hf)
        else
        begin
            $display("ERROR: not every instruction class was decoded, seen mask %h", class_seen);
            errors++;
        end
        assert (neg_imm_seen && pos_imm_seen)
        else
        begin
            $display("ERROR: immediates of both signs were not decoded");
            errors++;
        end
        report_test("format_decoding", err_before);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired before all fetches completed");
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        seed_value   = $urandom(SEED);
        clk          = 1'b0;
        rst          = 1'b1;
        start        = 1'b0;
        start_addr   = '0;
        fetch_len    = '0;
        dec_ready    = 1'b1;
        random_ready = 1'b0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        class_seen   = '0;
        neg_imm_seen = 1'b0;
        pos_imm_seen = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        run_fetch("cold_stream", 32'h100, 16, 16);
        run_fetch("warm_refetch", 32'h100, 16, 0);
        // Same index, different tag.
        run_fetch("conflict_far", 32'h100 + 64 * LINES, 4, 4);
        run_fetch("conflict_near", 32'h100, 4, 4);
        random_ready <= 1'b1;
        run_fetch("back_pressure", 32'h203, 40, 40);
        random_ready <= 1'b0;
        check_format_coverage();

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- testbench/tb_mem_model.sv
module tb_mem_model (
    input  logic             clk,
    input  logic             rst,
    input  logic             mem_req_valid,
    input  fetch_pkg::addr_t mem_req_addr,
    output logic             mem_req_ready,
    output fetch_pkg::word_t mem_req_data
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_DELAY = 5;

    int unsigned req_count;
    int unsigned wait_cnt;
    logic        pending;

    // Opcode cycles with the word address. The rest is an address hash.
    function automatic fetch_pkg::word_t mem_word(input fetch_pkg::addr_t addr);
        fetch_pkg::word_t mix;
        logic [6:0]       op;
        case (addr[3:2])
            2'd0:    op = isa_pkg::OP_REG;
            2'd1:    op = isa_pkg::OP_IMM;
            2'd2:    op = isa_pkg::OP_LOAD;
            default: op = 7'b1101111;
        endcase
        mix = (addr * 32'h9e37_79b1) ^ {addr[15:2], addr[31:16], 2'b00};
        return {mix[31:7], op};
    endfunction

    initial
    begin
        mem_req_ready = 1'b0;
        mem_req_data  = '0;
        req_count     = 0;
        wait_cnt      = 0;
        pending       = 1'b0;
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            mem_req_ready <= 1'b0;
            pending       <= 1'b0;
            wait_cnt      <= 0;
        end
        else if (mem_req_ready)
        begin
            // Handshake completes on this edge.
            mem_req_ready <= 1'b0;
            if (mem_req_valid)
            begin
                req_count <= req_count + 1;
            end
        end
        else if (pending)
        begin
            if (wait_cnt == 0)
            begin
                mem_req_ready <= 1'b1;
                mem_req_data  <= mem_word(mem_req_addr);
                pending       <= 1'b0;
            end
            else
            begin
                wait_cnt <= wait_cnt - 1;
            end
        end
        else if (mem_req_valid)
        begin
            pending  <= 1'b1;
            wait_cnt <= $urandom % (MAX_DELAY + 1);
        end
    end

endmodule

//--- hw/fetch_top.sv
module fetch_top #(
    parameter int LINES       = 16,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  fetch_pkg::addr_t      start_addr,
    input  fetch_pkg::len_t       fetch_len,
    output logic                  mem_req_valid,
    output fetch_pkg::addr_t      mem_req_addr,
    input  logic                  mem_req_ready,
    input  fetch_pkg::word_t      mem_req_data,
    output logic                  dec_valid,
    input  logic                  dec_ready,
    output fetch_pkg::addr_t      dec_pc,
    output isa_pkg::instr_class_t dec_class,
    output logic [4:0]            dec_rd,
    output logic [4:0]            dec_rs1,
    output logic [4:0]            dec_rs2,
    output fetch_pkg::word_t      dec_imm
);

    logic             req_valid;
    logic             req_ready;
    fetch_pkg::addr_t req_addr;
    logic             resp_valid;
    fetch_pkg::addr_t resp_addr;
    fetch_pkg::word_t resp_data;
    logic             credit_return;
    logic             q_valid;
    fetch_pkg::addr_t q_addr;
    fetch_pkg::word_t q_data;
    logic             q_pop;

    fetch_pc_gen #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_pc_gen (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .start_addr   (start_addr),
        .fetch_len    (fetch_len),
        .credit_return(credit_return),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_ready    (req_ready)
    );

    icache #(
        .LINES(LINES)
    ) u_icache (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_ready    (req_ready),
        .resp_valid   (resp_valid),
        .resp_addr    (resp_addr),
        .resp_data    (resp_data),
        .mem_req_valid(mem_req_valid),
        .mem_req_addr (mem_req_addr),
        .mem_req_ready(mem_req_ready),
        .mem_req_data (mem_req_data)
    );

    fetch_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clk          (clk),
        .rst          (rst),
        .push         (resp_valid),
        .push_addr    (resp_addr),
        .push_data    (resp_data),
        .q_valid      (q_valid),
        .q_addr       (q_addr),
        .q_data       (q_data),
        .q_pop        (q_pop),
        .credit_return(credit_return)
    );

    instr_predecode u_predecode (
        .clk      (clk),
        .rst      (rst),
        .q_valid  (q_valid),
        .q_addr   (q_addr),
        .q_data   (q_data),
        .q_pop    (q_pop),
        .dec_valid(dec_valid),
        .dec_ready(dec_ready),
        .dec_pc   (dec_pc),
        .dec_class(dec_class),
        .dec_rd   (dec_rd),
        .dec_rs1  (dec_rs1),
        .dec_rs2  (dec_rs2),
        .dec_imm  (dec_imm)
    );

endmodule

//--- hw/instr_predecode.sv
module instr_predecode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   q_valid,
    input  fetch_pkg::addr_t       q_addr,
    input  fetch_pkg::word_t       q_data,
    output logic                   q_pop,
    output logic                   dec_valid,
    input  logic                   dec_ready,
    output fetch_pkg::addr_t       dec_pc,
    output isa_pkg::instr_class_t  dec_class,
    output logic [4:0]             dec_rd,
    output logic [4:0]             dec_rs1,
    output logic [4:0]             dec_rs2,
    output fetch_pkg::word_t       dec_imm
);

    isa_pkg::instr_u       instr;
    isa_pkg::instr_class_t cls;
    logic [4:0]            rd;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    fetch_pkg::word_t      imm;

    assign instr = q_data;

    // Take a new entry when the output slot is free or draining.
    assign q_pop = q_valid && (!dec_valid || dec_ready);

    always_comb
    begin
        cls = isa_pkg::CLASS_OTHER;
        rd  = '0;
        rs1 = '0;
        rs2 = '0;
        imm = '0;
        case (instr.r.opcode)
            isa_pkg::OP_REG:
            begin
                cls = isa_pkg::CLASS_REG;
                rd  = instr.r.rd;
                rs1 = instr.r.rs1;
                rs2 = instr.r.rs2;
            end
            isa_pkg::OP_IMM,
            isa_pkg::OP_LOAD:
            begin
                cls = (instr.i.opcode == isa_pkg::OP_IMM) ? isa_pkg::CLASS_IMM
                                                          : isa_pkg::CLASS_LOAD;
                rd  = instr.i.rd;
                rs1 = instr.i.rs1;
                imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            default: cls = isa_pkg::CLASS_OTHER;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            dec_valid <= 1'b0;
        end
        else if (q_pop)
        begin
            dec_valid <= 1'b1;
        end
        else if (dec_ready)
        begin
            dec_valid <= 1'b0;
        end
    end

    // Fields only change on a pop, so they hold under back-pressure.
    always_ff @(posedge clk)
    begin
        if (q_pop)
        begin
            dec_pc    <= q_addr;
            dec_class <= cls;
            dec_rd    <= rd;
            dec_rs1   <= rs1;
            dec_rs2   <= rs2;
            dec_imm   <= imm;
        end
    end

endmodule

//--- hw/fetch_queue.sv
module fetch_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  fetch_pkg::addr_t push_addr,
    input  fetch_pkg::word_t push_data,
    output logic             q_valid,
    output fetch_pkg::addr_t q_addr,
    output fetch_pkg::word_t q_data,
    input  logic             q_pop,
    output logic             credit_return
);

    localparam int PTR_W   = $clog2(QUEUE_DEPTH);
    localparam int COUNT_W = $clog2(QUEUE_DEPTH + 1);

    fetch_pkg::addr_t addr_mem [QUEUE_DEPTH];
    fetch_pkg::word_t data_mem [QUEUE_DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               pop_ok;

    assign q_valid = (count != '0);
    assign q_addr  = addr_mem[rd_ptr];
    assign q_data  = data_mem[rd_ptr];
    assign pop_ok  = q_pop && q_valid;

    // The credit loop keeps pushes within depth.
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            addr_mem[wr_ptr] <= push_addr;
            data_mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (pop_ok)
            begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({push, pop_ok})
                2'b10:   count <= count + COUNT_W'(1);
                2'b01:   count <= count - COUNT_W'(1);
                default: count <= count;
            endcase
            // One credit back per removed entry.
            credit_return <= pop_ok;
        end
    end

endmodule

//--- hw/icache.sv
module icache #(
    parameter int LINES = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             req_valid,
    input  fetch_pkg::addr_t req_addr,
    output logic             req_ready,
    output logic             resp_valid,
    output fetch_pkg::addr_t resp_addr,
    output fetch_pkg::word_t resp_data,
    output logic             mem_req_valid,
    output fetch_pkg::addr_t mem_req_addr,
    input  logic             mem_req_ready,
    input  fetch_pkg::word_t mem_req_data
);

    localparam int ADDR_W  = $bits(fetch_pkg::addr_t);
    localparam int INDEX_W = $clog2(LINES);
    localparam int TAG_W   = ADDR_W - INDEX_W - fetch_pkg::OFFSET_W;
    localparam int INDEX_LSB = fetch_pkg::OFFSET_W;
    localparam int TAG_LSB   = fetch_pkg::OFFSET_W + INDEX_W;

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        REFILL
    } state_t;

    state_t state;
    state_t next_state;

    fetch_pkg::addr_t addr_q;
    logic [INDEX_W-1:0] index_q;
    logic [TAG_W-1:0]   tag_q;

    // One word per line.
    logic [LINES-1:0]   valid_bits;
    logic [TAG_W-1:0]   tag_mem  [LINES];
    fetch_pkg::word_t   data_mem [LINES];

    logic hit;
    logic refill_done;

    assign index_q = addr_q[TAG_LSB-1:INDEX_LSB];
    assign tag_q   = addr_q[ADDR_W-1:TAG_LSB];

    assign hit = valid_bits[index_q] && (tag_mem[index_q] == tag_q);

    assign req_ready  = (state == IDLE);
    assign resp_valid = (state == COMPARE) && hit;
    assign resp_addr  = addr_q;
    assign resp_data  = data_mem[index_q];

    // Memory request goes out straight from the compare cycle on a miss.
    assign mem_req_valid = ((state == COMPARE) && !hit) || (state == REFILL);
    assign mem_req_addr  = {addr_q[ADDR_W-1:INDEX_LSB], {fetch_pkg::OFFSET_W{1'b0}}};
    assign refill_done   = mem_req_valid && mem_req_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (req_valid)
                begin
                    next_state = COMPARE;
                end
            end
            COMPARE:
            begin
                if (hit)
                begin
                    next_state = IDLE;
                end
                else if (!mem_req_ready)
                begin
                    next_state = REFILL;
                end
            end
            REFILL:
            begin
                // Back to compare; the freshly written line hits there.
                if (mem_req_ready)
                begin
                    next_state = COMPARE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (req_valid && req_ready)
        begin
            addr_q <= req_addr;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_bits <= '0;
        end
        else if (refill_done)
        begin
            valid_bits[index_q] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (refill_done)
        begin
            tag_mem[index_q]  <= tag_q;
            data_mem[index_q] <= mem_req_data;
        end
    end

endmodule

//--- hw/fetch_pc_gen.sv
module fetch_pc_gen #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  fetch_pkg::addr_t start_addr,
    input  fetch_pkg::len_t  fetch_len,
    input  logic             credit_return,
    output logic             req_valid,
    output fetch_pkg::addr_t req_addr,
    input  logic             req_ready
);

    localparam int CREDIT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int ADDR_W = $bits(fetch_pkg::addr_t);

    fetch_pkg::addr_t pc;
    fetch_pkg::len_t  remaining;
    logic [CREDIT_W-1:0] credits;
    logic xfer;

    // Valid only while words remain and the queue has room.
    assign req_valid = (remaining != '0) && (credits != '0);
    assign req_addr  = pc;
    assign xfer      = req_valid && req_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc        <= '0;
            remaining <= '0;
        end
        else if (start && remaining == '0)
        begin
            // Align down to a word boundary.
            pc        <= {start_addr[ADDR_W-1:fetch_pkg::OFFSET_W],
                          {fetch_pkg::OFFSET_W{1'b0}}};
            remaining <= fetch_len;
        end
        else if (xfer)
        begin
            pc        <= pc + fetch_pkg::addr_t'(4);
            remaining <= remaining - fetch_pkg::len_t'(1);
        end
    end

    // One credit per queue entry.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            credits <= CREDIT_W'(QUEUE_DEPTH);
        end
        else
        begin
            case ({xfer, credit_return})
                2'b10:   credits <= credits - CREDIT_W'(1);
                2'b01:   credits <= credits + CREDIT_W'(1);
                default: credits <= credits;
            endcase
        end
    end

endmodule

//--- hw/isa_pkg.sv
package isa_pkg;

    // Register format.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // Immediate format for ALU and load instructions.
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Two views of one instruction word.
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    localparam logic [6:0] OP_REG  = 7'b0110011;
    localparam logic [6:0] OP_IMM  = 7'b0010011;
    localparam logic [6:0] OP_LOAD = 7'b0000011;

    typedef enum logic [1:0] {
        CLASS_REG,
        CLASS_IMM,
        CLASS_LOAD,
        CLASS_OTHER
    } instr_class_t;

endpackage

//--- hw/fetch_pkg.sv
package fetch_pkg;

    // Byte address as issued by the fetch path.
    typedef logic [31:0] addr_t;

    // Instruction or memory data word.
    typedef logic [31:0] word_t;

    // Byte offset inside a 32-bit word.
    localparam int OFFSET_W = 2;

    // Fetch length in words.
    typedef logic [7:0] len_t;

endpackage
